// File: files.f
+incdir+rtl
rtl/hps_io_pkg.sv
rtl/host_frame.sv
rtl/user_regs.sv
rtl/file_loader.sv
rtl/ps2_kbd_tx.sv
rtl/hps_io.sv
testbench/hps_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the hps_io testbench with Verilator, run it, and scan the log for failure

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

if ! verilator --binary --timing -f files.f --top-module hps_io_tb \
	-Mdir "$OBJ_DIR" -o hps_io_sim; then
	echo "verilator build failed"
	exit 1
fi

if ! "./$OBJ_DIR/hps_io_sim" > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation run returned an error"
	exit 1
fi

cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi

exit 0

// File: testbench/hps_io_tb.sv
// testbench for hps_io: clock, reset, host bus driver, reference models, ioctl and PS/2 monitor
`timescale 1ns/1ps
`default_nettype none

`include "hps_io_consts.svh"

module hps_io_tb
	import hps_io_pkg::*;
();

	localparam int PS2_DIV = 4;

	logic        clk_sys;
	logic        arst_n;
	host_bus_t   host;
	logic [31:0] status_in;
	logic        status_set;
	logic [15:0] host_dout;
	logic [1:0]  buttons;
	logic        forced_scandoubler;
	logic [15:0] joystick_0;
	logic [15:0] joystick_1;
	logic [31:0] status;
	logic [10:0] ps2_key;
	ioctl_t      ioctl;
	logic        ps2_kbd_clk;
	logic        ps2_kbd_data;

	int          errors;
	int          checks;
	int          test_err;
	int          nwords;
	int          kbd_total;
	logic        timed_out;
	logic [31:0] rnd;
	logic [31:0] req_val;
	logic [7:0]  cfg_val;
	logic [15:0] ext_hi;
	logic [15:0] ext_lo;
	logic [10:0] exp_key;
	logic [15:0] args[$];
	logic [15:0] replies[$];
	logic [7:0]  kbd_exp[$];
	logic [24:0] wr_addr[$];
	logic [7:0]  wr_data[$];

	// PS/2 monitor state
	int          frames_rx;
	int          bit_cnt;
	int          idle_low;
	logic        ps2_clk_q;
	logic        in_frame;
	logic [10:0] frame_bits;

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	hps_io #(
		.PS2_DIV (PS2_DIV)
	) hps_io_inst (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.host               (host),
		.status_in          (status_in),
		.status_set         (status_set),
		.host_dout          (host_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_key            (ps2_key),
		.ioctl              (ioctl),
		.ps2_kbd_clk        (ps2_kbd_clk),
		.ps2_kbd_data       (ps2_kbd_data)
	);

	//////////////////////////////
	// reference models

	// key event word after one KBD transfer made of the words in args
	function automatic logic [10:0] key_event(input logic [10:0] prev);
		logic [7:0] key;
		logic [7:0] b1;
		logic [7:0] b2;
		logic       skip;
		logic       pressed;
		logic       extended;
		key = 8'h00;
		b1 = 8'h00;
		b2 = 8'h00;
		skip = 1'b0;
		foreach (args[i]) begin
			if (args[i][15:8] == 8'hFF) begin
				skip = 1'b1;
			end else if (!skip) begin
				b2 = b1;
				b1 = key;
				key = args[i][7:0];
			end
		end
		pressed = b1 != 8'hF0;
		extended = pressed ? (b1 == 8'hE0) : (b2 == 8'hE0);
		if (skip) begin
			return prev;
		end
		return {~prev[10], pressed, extended, key};
	endfunction

	// bits in line order: start, data LSB first, odd parity, stop
	function automatic logic [10:0] ps2_frame(input logic [7:0] data);
		return {1'b1, ~^data, data, 1'b0};
	endfunction

	function automatic logic [24:0] download_addr(input int pos);
		return 25'(pos);
	endfunction

	//////////////////////////////
	// checks and host driver

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errors - test_err);
		test_err = errors;
	endtask

	// one word on the bus, the reply is read back before the next strobe
	task automatic send_word(input logic [15:0] word);
		host.din = word;
		host.strobe = 1'b1;
		@(negedge clk_sys);
		host.strobe = 1'b0;
		repeat (2) @(negedge clk_sys);
		replies.push_back(host_dout);
	endtask

	task automatic send_transfer(input logic [15:0] cmd);
		replies.delete();
		host.enable = 1'b1;
		send_word(cmd);
		foreach (args[i]) begin
			send_word(args[i]);
		end
		host.enable = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic kbd_transfer();
		foreach (args[i]) begin
			kbd_exp.push_back(args[i][7:0]);
		end
		kbd_total += args.size();
		exp_key = key_event(exp_key);
		send_transfer(`CMD_KBD);
		check("ps2_key", 32'(ps2_key), 32'(exp_key));
	endtask

	task automatic wait_frames(input int count);
		int cycles;
		cycles = 0;
		@(posedge clk_sys);
		while (frames_rx < count && !timed_out) begin
			@(posedge clk_sys);
			cycles++;
			if (cycles > 20000) begin
				timed_out = 1'b1;
				errors++;
				$display("timeout: only %0d of %0d keyboard frames arrived", frames_rx, count);
			end
		end
	endtask

	//////////////////////////////
	// ioctl write capture and PS/2 line monitor
	always @(negedge clk_sys) begin
		if (!arst_n) begin
			ps2_clk_q = 1'b1;
			in_frame = 1'b0;
			bit_cnt = 0;
			idle_low = 0;
			frames_rx = 0;
		end else begin
			if (ioctl.wr) begin
				wr_addr.push_back(ioctl.addr);
				wr_data.push_back(ioctl.dout);
			end
			if (ps2_clk_q && !ps2_kbd_clk) begin
				// falling edge of the keyboard clock
				if (!in_frame && idle_low > PS2_DIV) begin
					errors++;
					$display("keyboard data low for %0d cycles between frames at %0t",
						idle_low, $time);
				end
				in_frame = 1'b1;
				frame_bits = {ps2_kbd_data, frame_bits[10:1]};
				bit_cnt++;
				if (bit_cnt == 11) begin
					if (kbd_exp.size() == 0) begin
						errors++;
						$display("keyboard frame at %0t with no byte expected", $time);
					end else begin
						check("ps2_frame", 32'(frame_bits), 32'(ps2_frame(kbd_exp.pop_front())));
					end
					frames_rx++;
				end
			end else if (!ps2_clk_q && ps2_kbd_clk && bit_cnt == 11) begin
				in_frame = 1'b0;
				bit_cnt = 0;
			end
			// between frames only the start bit may pull data low, for half a clock period
			if (in_frame || ps2_kbd_data) begin
				idle_low = 0;
			end else begin
				idle_low++;
			end
			ps2_clk_q = ps2_kbd_clk;
		end
	end

	//////////////////////////////
	// test sequence
	initial begin
		rnd = $urandom(32'hafea7798);
		errors = 0;
		checks = 0;
		test_err = 0;
		kbd_total = 0;
		timed_out = 1'b0;
		exp_key = '0;
		arst_n = 1'b0;
		host = '0;
		status_in = '0;
		status_set = 1'b0;
		repeat (3) @(negedge clk_sys);
		arst_n = 1'b1;
		repeat (2) @(negedge clk_sys);

		// config and joysticks
		rnd = $urandom();
		cfg_val = rnd[7:0];
		args.delete();
		args.push_back({8'h00, cfg_val});
		send_transfer(`CMD_CFG);
		check("buttons", 32'(buttons), 32'(cfg_val[1:0]));
		check("forced_scandoubler", 32'(forced_scandoubler), 32'(cfg_val[4]));
		rnd = $urandom();
		args.delete();
		args.push_back(rnd[15:0]);
		send_transfer(`CMD_JOY0);
		args.delete();
		args.push_back(rnd[31:16]);
		send_transfer(`CMD_JOY1);
		check("joystick_0", 32'(joystick_0), 32'(rnd[15:0]));
		check("joystick_1", 32'(joystick_1), 32'(rnd[31:16]));
		end_test(1, "config and joysticks");

		// status word, then two requests from the core
		rnd = $urandom();
		args.delete();
		args.push_back(rnd[15:0]);
		args.push_back(rnd[31:16]);
		send_transfer(`CMD_STATUS);
		check("status", status, rnd);
		for (int i = 0; i < 2; i++) begin
			req_val = $urandom();
			status_in = req_val;
			status_set = 1'b1;
			@(negedge clk_sys);
			status_set = 1'b0;
			repeat (2) @(negedge clk_sys);
		end
		args.delete();
		args.push_back(16'h0000);
		args.push_back(16'h0000);
		send_transfer(`CMD_STATUS_REQ);
		check("host_dout tag", 32'(replies[0]), 32'({8'h00, `STATUS_REQ_TAG, 4'd2}));
		check("host_dout low", 32'(replies[1]), 32'(req_val[15:0]));
		check("host_dout high", 32'(replies[2]), 32'(req_val[31:16]));
		end_test(2, "status and status request");

		// file download
		rnd = $urandom();
		ext_hi = rnd[15:0];
		ext_lo = rnd[31:16];
		args.delete();
		args.push_back({8'h00, ext_hi[7:0] ^ ext_lo[7:0]});
		send_transfer(`CMD_FILE_INDEX);
		check("ioctl.index", 32'(ioctl.index), 32'(ext_hi[7:0] ^ ext_lo[7:0]));
		args.delete();
		args.push_back(ext_hi);
		args.push_back(ext_lo);
		send_transfer(`CMD_FILE_INFO);
		check("ioctl.file_ext", ioctl.file_ext, {ext_hi, ext_lo});
		args.delete();
		args.push_back(16'h0001);
		send_transfer(`CMD_FILE_TX);
		check("ioctl.download", 32'(ioctl.download), 32'd1);
		wr_addr.delete();
		wr_data.delete();
		nwords = 4 + int'(rnd[2:0]);
		args.delete();
		for (int i = 0; i < nwords; i++) begin
			rnd = $urandom();
			args.push_back(rnd[15:0]);
		end
		send_transfer(`CMD_FILE_DAT);
		check("ioctl write count", 32'(wr_addr.size()), 32'(nwords));
		foreach (args[i]) begin
			if (i < wr_addr.size()) begin
				check("ioctl.addr", 32'(wr_addr[i]), 32'(download_addr(i)));
				check("ioctl.dout", 32'(wr_data[i]), 32'(args[i][7:0]));
			end
		end
		args.delete();
		args.push_back(16'h0000);
		send_transfer(`CMD_FILE_TX);
		check("ioctl.download", 32'(ioctl.download), 32'd0);
		check("ioctl.addr", 32'(ioctl.addr), 32'(download_addr(nwords)));
		end_test(3, "file download");

		// keyboard events, top bit clear keeps keys away from E0 and F0
		rnd = $urandom();
		args.delete();
		args.push_back({9'h000, rnd[6:0]});
		kbd_transfer();
		args.delete();
		args.push_back(16'h00F0);
		args.push_back({9'h000, rnd[14:8]});
		kbd_transfer();
		args.delete();
		args.push_back(16'h00E0);
		args.push_back({9'h000, rnd[22:16]});
		kbd_transfer();
		args.delete();
		args.push_back(16'h00E0);
		args.push_back(16'h00F0);
		args.push_back({9'h000, rnd[30:24]});
		kbd_transfer();
		rnd = $urandom();
		args.delete();
		args.push_back({9'h000, rnd[6:0]});
		args.push_back({8'hFF, rnd[15:8]});
		args.push_back({9'h000, rnd[22:16]});
		kbd_transfer();
		end_test(4, "keyboard events");

		// serial keyboard frames
		wait_frames(kbd_total);
		repeat (16) @(negedge clk_sys);
		check("ps2 clock falls after last frame", 32'(bit_cnt), 32'd0);
		check("ps2_kbd_clk idle", 32'(ps2_kbd_clk), 32'd1);
		check("ps2_kbd_data idle", 32'(ps2_kbd_data), 32'd1);
		end_test(5, "keyboard frames");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/hps_io.sv
// top level: host bus framing, user registers, file download and keyboard transmitter
`timescale 1ns/1ps
`default_nettype none

`include "hps_io_consts.svh"

module hps_io
	import hps_io_pkg::*;
#(
	parameter int PS2_DIV = 2000
) (
	input  logic        clk_sys,
	input  logic        arst_n,
	input  host_bus_t   host,
	input  logic [31:0] status_in,
	input  logic        status_set,
	output logic [15:0] host_dout,
	output logic [1:0]  buttons,
	output logic        forced_scandoubler,
	output logic [15:0] joystick_0,
	output logic [15:0] joystick_1,
	output logic [31:0] status,
	output logic [10:0] ps2_key,
	output ioctl_t      ioctl,
	output logic        ps2_kbd_clk,
	output logic        ps2_kbd_data
);

	host_frame_t            frame;
	logic [`HPS_WORD_W-1:0] din_q;
	logic [7:0]             kbd_byte;
	logic                   kbd_we;

	// the host may change din after its strobe, peers see it a cycle later
	always_ff @(posedge clk_sys) begin
		if (host.strobe) begin
			din_q <= host.din;
		end
	end

	host_frame host_frame_inst (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.bus     (host),
		.frame   (frame)
	);

	user_regs user_regs_inst (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.frame              (frame),
		.din                (din_q),
		.status_in          (status_in),
		.status_set         (status_set),
		.cfg_buttons        (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ps2_key            (ps2_key),
		.kbd_byte           (kbd_byte),
		.kbd_we             (kbd_we),
		.reply              (host_dout)
	);

	file_loader file_loader_inst (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.frame   (frame),
		.din     (din_q),
		.ioctl   (ioctl)
	);

	ps2_kbd_tx #(
		.PS2_DIV (PS2_DIV)
	) ps2_kbd_tx_inst (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.kbd_byte (kbd_byte),
		.kbd_we   (kbd_we),
		.ps2_clk  (ps2_kbd_clk),
		.ps2_data (ps2_kbd_data)
	);

endmodule

`default_nettype wire

// File: rtl/ps2_kbd_tx.sv
// PS/2 clock divider, keyboard byte FIFO and serial frame transmitter
`timescale 1ns/1ps
`default_nettype none

`include "hps_io_consts.svh"

module ps2_kbd_tx
	import hps_io_pkg::*;
#(
	parameter int PS2_DIV = 2000
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic [7:0] kbd_byte,
	input  logic       kbd_we,
	output logic       ps2_clk,
	output logic       ps2_data
);

	localparam int DIV_W = (PS2_DIV > 1) ? $clog2(PS2_DIV) : 1;
	localparam int GAP_W = $clog2(`PS2_GAP + 1);
	localparam int FB = `PS2_FIFO_BITS;

	logic [DIV_W-1:0] div_cnt;
	logic             div_ph;
	logic             div_tick;
	logic             rise_tick;
	logic             fall_tick;

	logic [7:0]  fifo [1<<FB];
	logic [FB:0] wptr;
	logic [FB:0] rptr;
	logic        fifo_empty;
	logic        fifo_full;

	ps2_tx_state_e    state;
	logic [GAP_W-1:0] gap_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       tx_byte;
	logic             parity;
	logic             bit_on;

	//////////////////////////////
	// clock divider, period of 2*PS2_DIV
	assign div_tick = div_cnt == DIV_W'(PS2_DIV - 1);
	assign rise_tick = div_tick & ~div_ph;
	assign fall_tick = div_tick & div_ph;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			div_ph <= 1'b0;
		end else if (div_tick) begin
			div_cnt <= '0;
			div_ph <= ~div_ph;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// byte FIFO, writes when full are dropped
	assign fifo_empty = wptr == rptr;
	assign fifo_full = (wptr[FB] != rptr[FB]) && (wptr[FB-1:0] == rptr[FB-1:0]);

	always_ff @(posedge clk_sys) begin
		if (kbd_we && !fifo_full) begin
			fifo[wptr[FB-1:0]] <= kbd_byte;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wptr <= '0;
		end else if (kbd_we && !fifo_full) begin
			wptr <= wptr + 1'b1;
		end
	end

	//////////////////////////////
	// frame transmitter, bits change on the rising half
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= ps2_idle;
			rptr <= '0;
			gap_cnt <= '0;
			bit_cnt <= '0;
			parity <= 1'b1;
			bit_on <= 1'b0;
			ps2_data <= 1'b1;
			ps2_clk <= 1'b1;
		end else begin
			if (rise_tick) begin
				ps2_clk <= 1'b1;
				bit_on <= 1'b0;
				case (state)
					ps2_idle: begin
						ps2_data <= 1'b1;
						gap_cnt <= '0;
						if (!fifo_empty) begin
							state <= ps2_gap;
						end
					end
					ps2_gap: begin
						if (gap_cnt == GAP_W'(`PS2_GAP - 1)) begin
							// start bit
							ps2_data <= 1'b0;
							bit_on <= 1'b1;
							rptr <= rptr + 1'b1;
							bit_cnt <= '0;
							parity <= 1'b1;
							state <= hps_io_pkg::ps2_data;
						end else begin
							gap_cnt <= gap_cnt + 1'b1;
						end
					end
					hps_io_pkg::ps2_data: begin
						ps2_data <= tx_byte[0];
						bit_on <= 1'b1;
						parity <= parity ^ tx_byte[0];
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= ps2_parity;
						end
					end
					ps2_parity: begin
						ps2_data <= parity;
						bit_on <= 1'b1;
						state <= ps2_stop;
					end
					ps2_stop: begin
						ps2_data <= 1'b1;
						bit_on <= 1'b1;
						state <= ps2_idle;
					end
					default: state <= ps2_idle;
				endcase
			end
			// the device samples on this falling edge
			if (fall_tick) begin
				ps2_clk <= ~bit_on;
			end
		end
	end

	// byte shifter, LSB first
	always_ff @(posedge clk_sys) begin
		if (rise_tick) begin
			if (state == ps2_gap) begin
				tx_byte <= fifo[rptr[FB-1:0]];
			end else if (state == hps_io_pkg::ps2_data) begin
				tx_byte <= {1'b0, tx_byte[7:1]};
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/file_loader.sv
// file download sequencer for the ioctl outputs
`timescale 1ns/1ps
`default_nettype none

`include "hps_io_consts.svh"

module file_loader
	import hps_io_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  host_frame_t            frame,
	input  logic [`HPS_WORD_W-1:0] din,
	output ioctl_t                 ioctl
);

	logic                     download;
	logic                     wr_d;
	logic                     wr;
	logic [`IOCTL_ADDR_W-1:0] addr;
	logic [`IOCTL_ADDR_W-1:0] addr_out;
	logic [7:0]               index;
	logic [`IOCTL_DATA_W-1:0] dout;
	logic [31:0]              file_ext;

	assign ioctl = '{
		download: download,
		wr:       wr,
		index:    index,
		addr:     addr_out,
		dout:     dout,
		file_ext: file_ext
	};

	// control side
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			download <= 1'b0;
			wr_d <= 1'b0;
			wr <= 1'b0;
			addr <= '0;
		end else begin
			// write strobe lags the data word by one more cycle
			wr <= wr_d;
			wr_d <= frame.arg_stb && frame.cmd == cmd_file_dat;
			if (frame.arg_stb) begin
				if (frame.cmd == cmd_file_tx) begin
					download <= |din[7:0];
					if (|din[7:0]) begin
						addr <= '0;
					end
				end else if (frame.cmd == cmd_file_dat) begin
					addr <= addr + 1'b1;
				end
			end
		end
	end

	// payload side
	always_ff @(posedge clk_sys) begin
		if (frame.arg_stb) begin
			case (frame.cmd)
				cmd_file_index: index <= din[7:0];
				cmd_file_info: begin
					// extension arrives upper half first
					if (frame.idx == `HPS_IDX_W'(1)) begin
						file_ext[31:16] <= din;
					end else if (frame.idx == `HPS_IDX_W'(2)) begin
						file_ext[15:0] <= din;
					end
				end
				cmd_file_tx: begin
					// at stop the final count becomes visible
					if (~|din[7:0]) begin
						addr_out <= addr;
					end
				end
				cmd_file_dat: begin
					addr_out <= addr;
					dout <= din[`IOCTL_DATA_W-1:0];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/user_regs.sv
// config, joystick and status registers, status request reply and keyboard event decode
`timescale 1ns/1ps
`default_nettype none

`include "hps_io_consts.svh"

module user_regs
	import hps_io_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  host_frame_t            frame,
	input  logic [`HPS_WORD_W-1:0] din,
	input  logic [31:0]            status_in,
	input  logic                   status_set,
	output logic [1:0]             cfg_buttons,
	output logic                   forced_scandoubler,
	output logic [15:0]            joystick_0,
	output logic [15:0]            joystick_1,
	output logic [31:0]            status,
	output logic [10:0]            ps2_key,
	output logic [7:0]             kbd_byte,
	output logic                   kbd_we,
	output logic [15:0]            reply
);

	logic [7:0]  cfg;
	logic        status_set_d;
	logic [3:0]  req_cnt;
	logic [31:0] status_req;
	logic [31:0] key_raw;
	logic        key_skip;
	logic        pressed;
	logic        extended;
	logic        kbd_arg;

	// bit 2, 3 and 5 of cfg belong to the system shell
	assign cfg_buttons = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	assign kbd_arg = frame.arg_stb && frame.cmd == cmd_kbd;

	// break code is F0, extended prefix E0 comes before the key or before F0
	assign pressed = key_raw[15:8] != 8'hF0;
	assign extended = pressed ? (key_raw[15:8] == 8'hE0) : (key_raw[23:16] == 8'hE0);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cfg <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status <= '0;
			status_set_d <= 1'b0;
			req_cnt <= '0;
			key_raw <= '0;
			key_skip <= 1'b0;
			ps2_key <= '0;
			kbd_we <= 1'b0;
			reply <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set & ~status_set_d) begin
				req_cnt <= req_cnt + 1'b1;
			end

			kbd_we <= kbd_arg;

			//////////////////////////////
			// command word
			if (frame.cmd_stb) begin
				reply <= '0;
				key_skip <= 1'b0;
				if (frame.cmd == cmd_status_req) begin
					reply <= {8'h00, `STATUS_REQ_TAG, req_cnt};
				end
				if (frame.cmd == cmd_kbd) begin
					key_raw <= '0;
				end
			end

			//////////////////////////////
			// argument words
			if (frame.arg_stb) begin
				reply <= '0;
				case (frame.cmd)
					cmd_cfg: cfg <= din[7:0];
					cmd_joy0: joystick_0 <= din;
					cmd_joy1: joystick_1 <= din;
					cmd_status: begin
						if (frame.idx == `HPS_IDX_W'(1)) begin
							status[15:0] <= din;
						end else if (frame.idx == `HPS_IDX_W'(2)) begin
							status[31:16] <= din;
						end
					end
					cmd_status_req: begin
						if (frame.idx == `HPS_IDX_W'(1)) begin
							reply <= status_req[15:0];
						end else if (frame.idx == `HPS_IDX_W'(2)) begin
							reply <= status_req[31:16];
						end
					end
					cmd_kbd: begin
						if (&din[15:8]) begin
							key_skip <= 1'b1;
						end else if (!key_skip) begin
							key_raw <= {key_raw[23:0], din[7:0]};
						end
					end
					default: ;
				endcase
			end

			// end of transfer, update the key event
			if (frame.done) begin
				reply <= '0;
				key_skip <= 1'b0;
				if (frame.cmd == cmd_kbd && !key_skip) begin
					ps2_key <= {~ps2_key[10], pressed, extended, key_raw[7:0]};
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set & ~status_set_d) begin
			status_req <= status_in;
		end
		// every keyboard byte goes to the transmitter, skipped or not
		if (kbd_arg) begin
			kbd_byte <= din[7:0];
		end
	end

endmodule

`default_nettype wire

// File: rtl/host_frame.sv
// host bus transfer framing: command latch, word index and per-word pulses
`timescale 1ns/1ps
`default_nettype none

module host_frame
	import hps_io_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  host_bus_t   bus,
	output host_frame_t frame
);

	logic en_d;
	logic stb_d;
	logic have_cmd;
	logic stb_rise;

	assign stb_rise = bus.strobe & ~stb_d;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			en_d <= 1'b0;
			stb_d <= 1'b0;
			have_cmd <= 1'b0;
			frame <= '0;
		end else begin
			en_d <= bus.enable;
			stb_d <= bus.strobe;
			frame.cmd_stb <= 1'b0;
			frame.arg_stb <= 1'b0;
			// end of transfer, one cycle after enable drops
			frame.done <= en_d & ~bus.enable;

			// command is kept through done, then cleared
			if (frame.done) begin
				frame.cmd <= cmd_none;
			end

			if (!bus.enable) begin
				have_cmd <= 1'b0;
			end else if (stb_rise) begin
				if (!have_cmd) begin
					// first word of the transfer
					frame.cmd <= host_cmd_e'(bus.din);
					frame.idx <= '0;
					frame.cmd_stb <= 1'b1;
					have_cmd <= 1'b1;
				end else begin
					if (~&frame.idx) begin
						frame.idx <= frame.idx + 1'b1;
					end
					frame.arg_stb <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/hps_io_pkg.sv
// host bus, transfer framing, download and keyboard transmitter types
`default_nettype none

`include "hps_io_consts.svh"

package hps_io_pkg;

	typedef enum logic [`HPS_WORD_W-1:0] {
		cmd_none       = 16'h0000,
		cmd_cfg        = `CMD_CFG,
		cmd_joy0       = `CMD_JOY0,
		cmd_joy1       = `CMD_JOY1,
		cmd_kbd        = `CMD_KBD,
		cmd_status     = `CMD_STATUS,
		cmd_status_req = `CMD_STATUS_REQ,
		cmd_file_tx    = `CMD_FILE_TX,
		cmd_file_dat   = `CMD_FILE_DAT,
		cmd_file_index = `CMD_FILE_INDEX,
		cmd_file_info  = `CMD_FILE_INFO
	} host_cmd_e;

	// raw host bus, enable is the OR of both enable lines
	typedef struct packed {
		logic                   enable;
		logic                   strobe;
		logic [`HPS_WORD_W-1:0] din;
	} host_bus_t;

	typedef struct packed {
		host_cmd_e             cmd;
		logic [`HPS_IDX_W-1:0] idx;
		logic                  arg_stb;
		logic                  cmd_stb;
		logic                  done;
	} host_frame_t;

	typedef enum logic [2:0] {
		ps2_idle,
		ps2_gap,
		ps2_data,
		ps2_parity,
		ps2_stop
	} ps2_tx_state_e;

	typedef struct packed {
		logic                     download;
		logic                     wr;
		logic [7:0]               index;
		logic [`IOCTL_ADDR_W-1:0] addr;
		logic [`IOCTL_DATA_W-1:0] dout;
		logic [31:0]              file_ext;
	} ioctl_t;

endpackage

`default_nettype wire

// File: rtl/hps_io_consts.svh
// host bus widths, command codes, download widths and keyboard transmitter constants
`ifndef HPS_IO_CONSTS_SVH
`define HPS_IO_CONSTS_SVH

// host bus
`define HPS_WORD_W 16
`define HPS_IDX_W 10

// command words
`define CMD_CFG 16'h0001
`define CMD_JOY0 16'h0002
`define CMD_JOY1 16'h0003
`define CMD_KBD 16'h0005
`define CMD_STATUS 16'h001E
`define CMD_STATUS_REQ 16'h0029
`define CMD_FILE_TX 16'h0053
`define CMD_FILE_DAT 16'h0054
`define CMD_FILE_INDEX 16'h0055
`define CMD_FILE_INFO 16'h0056

// status request reply tag, upper nibble of the first reply
`define STATUS_REQ_TAG 4'hA

// file download
`define IOCTL_ADDR_W 25
`define IOCTL_DATA_W 8

// keyboard transmitter
`define PS2_FIFO_BITS 5
`define PS2_GAP 4

`endif
